//--- life_sim.f
verilog/life_pkg.sv
verilog/world_buffer.sv
verilog/life_engine.sv
verilog/generation_control.sv
verilog/life_sim.sv
sim/life_sim_assertions.sv
sim/life_sim_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the Life simulator regression with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module life_sim_tb -f life_sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vlife_sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- sim/life_sim_tb.sv
// Life simulator testbench
// stimulus table, xorshift source, reference Life model, checks and watchdog
module life_sim_tb;

    typedef logic [life_pkg::CELL_COUNT-1:0] world_t;

    logic                 clk = 1'b0;
    logic                 rst, start, run, busy, finished;
    logic                 load_we, load_status, peek_status;
    life_pkg::cell_addr_t load_id, peek_id;
    life_pkg::gen_count_t generations;

    // table rows, mode 0 plain, 1 random run gaps, 2 extra start while busy
    string  name_q [$];
    world_t seed_q [$];
    int     gens_q [$];
    int     mode_q [$];
    int     max_gens = 0;

    logic [31:0] rng_state = 32'h75856175;
    int          fail_count = 0;

    life_sim DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // one generation, neighbours at row and column steps folded into a linear
    // offset and wrapped over the whole world
    function automatic world_t life_step(input world_t w);
        world_t nxt;
        int     n;
        for (int c = 0; c < life_pkg::CELL_COUNT; c++) begin
            n = 0;
            for (int k = 0; k < 9; k++) begin
                if (k != 4) begin
                    n += int'(w[(c + (k / 3 - 1) * life_pkg::WORLD_WIDTH + k % 3 - 1
                        + life_pkg::CELL_COUNT) % life_pkg::CELL_COUNT]);
                end
            end
            nxt[c] = w[c] ? (n == 2 || n == 3) : (n == 3);
        end
        return nxt;
    endfunction

    task automatic add_row(input string name, input world_t seed, input int gens, input int mode);
        name_q.push_back(name);
        seed_q.push_back(seed);
        gens_q.push_back(gens);
        mode_q.push_back(mode);
        if (gens > max_gens) begin
            max_gens = gens;
        end
    endtask

    // load a seed, run it, then peek every cell and compare with the model
    task automatic run_test(input int idx);
        world_t      seed;
        world_t      expected;
        world_t      actual;
        logic [31:0] gap_rand;
        seed = seed_q[idx];
        expected = seed;
        repeat (gens_q[idx])
            expected = life_step(expected);
        for (int i = 0; i < life_pkg::CELL_COUNT; i++) begin
            @(posedge clk);
            load_we <= 1'b1;
            load_id <= life_pkg::cell_addr_t'(i);
            load_status <= seed[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        start <= 1'b1;
        generations <= life_pkg::gen_count_t'(gens_q[idx]);
        @(posedge clk);
        start <= 1'b0;
        if (mode_q[idx] == 2) begin
            // a larger request while busy must not take effect
            repeat (3) @(posedge clk);
            start <= 1'b1;
            generations <= life_pkg::gen_count_t'(gens_q[idx] + 1);
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (finished !== 1'b1) begin
            @(posedge clk);
            gap_rand = next_random();
            // run low on about a quarter of the cycles in gap mode
            run <= (mode_q[idx] != 1) || (gap_rand[1:0] != 2'b00);
            @(negedge clk);
        end
        @(posedge clk);
        run <= 1'b1;
        for (int i = 0; i < life_pkg::CELL_COUNT; i++) begin
            peek_id <= life_pkg::cell_addr_t'(i);
            @(posedge clk);
            @(negedge clk);
            actual[i] = peek_status;
            @(posedge clk);
        end
        assert (actual === expected) begin
            $display("ok     %s, %0d generations", name_q[idx], gens_q[idx]);
        end else begin
            $display("FAILED %s expected %h actual %h", name_q[idx], expected, actual);
            fail_count++;
        end
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        start = 1'b0;
        run = 1'b1;
        generations = '0;
        load_we = 1'b0;
        load_id = '0;
        load_status = 1'b0;
        peek_id = '0;
        // seed bit index is row * 6 + column
        add_row("zero_world", 36'h000000000, 1, 0);
        add_row("zero_gens", 36'h000007102, 0, 0);
        add_row("block", 36'h00030C000, 3, 0);
        add_row("blinker_1", 36'h00000E000, 1, 0);
        add_row("blinker_2", 36'h00000E000, 2, 0);
        add_row("seam_column", 36'h200000208, 2, 0);
        add_row("glider_wrap", 36'h000007102, 12, 0);
        add_row("full_square", 36'h00038E380, 2, 0);
        add_row("all_live", 36'hFFFFFFFFF, 1, 0);
        for (int k = 0; k < 5; k++) begin
            r = next_random();
            add_row($sformatf("random_%0d", k), {r[3:0], next_random()},
                int'(r[5:4]) + 1, k / 4);
        end
        add_row("glider_paused", 36'h000007102, 4, 1);
        add_row("restart_ignored", 36'h00000E000, 1, 2);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (busy === 1'b0) else begin
            $display("busy is not low after reset");
            fail_count++;
        end
        for (int t = 0; t < name_q.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d failed", name_q.size(), fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // limit scales with the table size and the longest generation count
    initial begin
        wait (rst === 1'b0);
        repeat (name_q.size() * (max_gens + 1) * life_pkg::CELL_COUNT * 20) @(posedge clk);
        $display("timeout, a test never reached finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sim/life_sim_assertions.sv
// concurrent checks on the update engine and generation controller
// bound into the simulator top level
module life_sim_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    start,
    input logic                    busy,
    input logic                    finished,
    input logic                    we,
    input logic                    swap,
    input life_pkg::engine_state_t engine_state
);

    // engine writes land only inside a running generation, never in the swap cycle
    write_while_busy: assert property (@(posedge clk) disable iff (rst)
        we |-> (busy && !swap))
        else $error("write strobe outside a running generation");

    // busy rises only after a start
    busy_needs_start: assert property (@(posedge clk) (rst || (!busy && !start)) |=> !busy)
        else $error("busy rose without a start");

    finished_one_cycle: assert property (@(posedge clk) disable iff (rst)
        finished |=> !finished)
        else $error("finished held for more than one cycle");

    // banks swap only between generations
    swap_engine_parked: assert property (@(posedge clk) disable iff (rst)
        swap |-> (engine_state == life_pkg::IDLE || engine_state == life_pkg::NEXT_CELL))
        else $error("bank swap while the engine is inside a cell");

endmodule

bind life_sim life_sim_assertions u_assertions (
    .clk(clk), .rst(rst), .start(start), .busy(busy), .finished(finished),
    .we(we), .swap(swap), .engine_state(u_engine.state)
);

//--- verilog/life_sim.sv
// Life simulator top level
// connects the cell buffer, update engine and generation controller
module life_sim (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  life_pkg::gen_count_t generations,
    input  logic                 run,
    input  logic                 load_we,
    input  life_pkg::cell_addr_t load_id,
    input  logic                 load_status,
    input  life_pkg::cell_addr_t peek_id,
    output logic                 peek_status,
    output logic                 busy,
    output logic                 finished
);

    life_pkg::cell_addr_t id;
    logic                 r_status;
    logic                 w_status;
    logic                 we;
    logic                 engine_start;
    logic                 engine_done;
    logic                 swap;

    // host loads only land while no generation is running
    world_buffer u_buffer (
        .clk(clk), .rst(rst),
        .rd_id(id), .rd_status(r_status),
        .wr_en(we), .wr_id(id), .wr_status(w_status),
        .load_we(load_we & ~busy), .load_id(load_id), .load_status(load_status),
        .peek_id(peek_id), .peek_status(peek_status),
        .swap(swap)
    );

    life_engine u_engine (
        .clk(clk), .rst(rst), .start(engine_start), .run(run),
        .id(id), .r_status(r_status), .w_status(w_status), .we(we), .done(engine_done)
    );

    generation_control u_control (
        .clk(clk), .rst(rst), .start(start), .generations(generations),
        .engine_start(engine_start), .engine_done(engine_done),
        .swap(swap), .busy(busy), .finished(finished)
    );

endmodule

//--- verilog/generation_control.sv
// generation sequencer
// launches the engine once per generation and swaps banks in between
module generation_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  life_pkg::gen_count_t generations,
    output logic                 engine_start,
    input  logic                 engine_done,
    output logic                 swap,
    output logic                 busy,
    output logic                 finished
);

    life_pkg::ctrl_state_t state;

    // generations still to run, including the one in progress
    life_pkg::gen_count_t gens_left;

    assign engine_start = (state == life_pkg::CTRL_LAUNCH);
    assign swap = (state == life_pkg::CTRL_SWAP);
    assign busy = (state != life_pkg::CTRL_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= life_pkg::CTRL_IDLE;
            gens_left <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (state)
                life_pkg::CTRL_IDLE: begin
                    // start is only looked at here, so a start while busy is dropped
                    if (start) begin
                        if (generations == '0) begin
                            finished <= 1'b1;
                        end else begin
                            gens_left <= generations;
                            state <= life_pkg::CTRL_LAUNCH;
                        end
                    end
                end
                life_pkg::CTRL_LAUNCH: begin
                    state <= life_pkg::CTRL_WAIT_DONE;
                end
                life_pkg::CTRL_WAIT_DONE: begin
                    if (engine_done) begin
                        gens_left <= gens_left - 1'b1;
                        state <= life_pkg::CTRL_SWAP;
                    end
                end
                life_pkg::CTRL_SWAP: begin
                    // back bank becomes front at this edge
                    if (gens_left == '0) begin
                        finished <= 1'b1;
                        state <= life_pkg::CTRL_IDLE;
                    end else begin
                        state <= life_pkg::CTRL_LAUNCH;
                    end
                end
                default: state <= life_pkg::CTRL_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/life_engine.sv
// cell-serial Life update engine
// walks every cell, counts live neighbours and writes the next state
module life_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 run,
    output life_pkg::cell_addr_t id,
    input  logic                 r_status,
    output logic                 w_status,
    output logic                 we,
    output logic                 done
);

    life_pkg::engine_state_t state;
    life_pkg::engine_state_t state_next;

    // current cell and neighbour position
    life_pkg::cell_addr_t cid;
    life_pkg::npos_t      npos;
    life_pkg::ncount_t    live_count;

    // wrapped neighbour address
    life_pkg::cell_addr_t nid;
    int                   nbr_offset;
    int                   nbr_sum;

    logic last_cell;
    logic last_npos;

    assign last_cell = (cid == life_pkg::cell_addr_t'(life_pkg::CELL_COUNT - 1));
    assign last_npos = (npos == life_pkg::npos_t'(life_pkg::NEIGHBOURS_COUNT - 1));

    always_comb begin
        state_next = state;
        case (state)
            life_pkg::IDLE: begin
                if (start && !done) begin
                    state_next = life_pkg::NEXT_CELL;
                end
            end
            life_pkg::NEXT_CELL: begin
                // run low parks the engine here between cells
                if (done) begin
                    state_next = life_pkg::IDLE;
                end else if (run) begin
                    state_next = life_pkg::NEIGHBOURS;
                end
            end
            life_pkg::NEIGHBOURS: begin
                if (last_npos) begin
                    state_next = life_pkg::CURRENT_CELL;
                end
            end
            life_pkg::CURRENT_CELL: state_next = life_pkg::UPDATE_CELL;
            life_pkg::UPDATE_CELL: state_next = life_pkg::NEXT_CELL;
            default: state_next = life_pkg::IDLE;
        endcase
    end

    // neighbour offsets are linear, wrapped modulo CELL_COUNT
    always_comb begin
        case (npos)
            3'd0: nbr_offset = -(life_pkg::WORLD_WIDTH + 1);
            3'd1: nbr_offset = -life_pkg::WORLD_WIDTH;
            3'd2: nbr_offset = -(life_pkg::WORLD_WIDTH - 1);
            3'd3: nbr_offset = -1;
            3'd4: nbr_offset = 1;
            3'd5: nbr_offset = life_pkg::WORLD_WIDTH - 1;
            3'd6: nbr_offset = life_pkg::WORLD_WIDTH;
            default: nbr_offset = life_pkg::WORLD_WIDTH + 1;
        endcase
        nbr_sum = int'(cid) + nbr_offset;
        if (nbr_sum < 0) begin
            nbr_sum = nbr_sum + life_pkg::CELL_COUNT;
        end else if (nbr_sum >= life_pkg::CELL_COUNT) begin
            nbr_sum = nbr_sum - life_pkg::CELL_COUNT;
        end
        nid = life_pkg::cell_addr_t'(nbr_sum);
    end

    // neighbours first, then the cell itself; the write reuses the cell address
    assign id = (state == life_pkg::NEIGHBOURS) ? nid : cid;
    assign we = (state == life_pkg::UPDATE_CELL);

    // in UPDATE_CELL r_status is the cell's own current state
    assign w_status = r_status ? (live_count == 4'd2 || live_count == 4'd3)
                               : (live_count == 4'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= life_pkg::IDLE;
            cid <= '0;
            npos <= '0;
            live_count <= '0;
            done <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                life_pkg::IDLE: begin
                    cid <= '0;
                    npos <= '0;
                    live_count <= '0;
                    done <= 1'b0;
                end
                life_pkg::NEIGHBOURS: begin
                    npos <= npos + 1'b1;
                    // read data trails the address by one cycle
                    if (npos != 3'd0) begin
                        live_count <= live_count + life_pkg::ncount_t'(r_status);
                    end
                end
                life_pkg::CURRENT_CELL: begin
                    // last neighbour arrives here
                    live_count <= live_count + life_pkg::ncount_t'(r_status);
                end
                life_pkg::UPDATE_CELL: begin
                    live_count <= '0;
                    if (last_cell) begin
                        cid <= '0;
                        done <= 1'b1;
                    end else begin
                        cid <= cid + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/world_buffer.sv
// two-bank single-bit cell memory
// engine reads and host peeks from the front bank, engine writes to the back bank
module world_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  life_pkg::cell_addr_t rd_id,
    output logic                 rd_status,
    input  logic                 wr_en,
    input  life_pkg::cell_addr_t wr_id,
    input  logic                 wr_status,
    input  logic                 load_we,
    input  life_pkg::cell_addr_t load_id,
    input  logic                 load_status,
    input  life_pkg::cell_addr_t peek_id,
    output logic                 peek_status,
    input  logic                 swap
);

    // bank[front] holds the current generation
    logic [life_pkg::CELL_COUNT-1:0] bank [2];
    logic                            front;

    // front select flips once per finished generation
    always_ff @(posedge clk) begin
        if (rst) begin
            front <= 1'b0;
        end else if (swap) begin
            front <= ~front;
        end
    end

    // next generation goes into the back bank
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank[~front][wr_id] <= wr_status;
        end
    end

    // seed pattern goes straight into the front bank
    always_ff @(posedge clk) begin
        if (load_we) begin
            bank[front][load_id] <= load_status;
        end
    end

    // registered reads, one cycle of latency on both ports
    always_ff @(posedge clk) begin
        rd_status <= bank[front][rd_id];
        peek_status <= bank[front][peek_id];
    end

endmodule

//--- verilog/life_pkg.sv
// world dimensions, vector typedefs and FSM state encodings
// shared by the Life simulator RTL and testbench
package life_pkg;

    // world geometry
    localparam int WORLD_WIDTH = 6;
    localparam int WORLD_HEIGHT = 6;
    localparam int CELL_COUNT = WORLD_WIDTH * WORLD_HEIGHT;
    localparam int ADDRW = $clog2(CELL_COUNT);

    // every cell has eight neighbours, so a live count can reach 8
    localparam int NEIGHBOURS_COUNT = 8;

    // width of a requested generation count
    localparam int GEN_W = 8;

    // linear cell index, row * WORLD_WIDTH + column
    typedef logic [ADDRW-1:0] cell_addr_t;

    // live neighbour count, 0 to 8
    typedef logic [$clog2(NEIGHBOURS_COUNT + 1)-1:0] ncount_t;

    // neighbour position, 0 to 7
    typedef logic [$clog2(NEIGHBOURS_COUNT)-1:0] npos_t;

    typedef logic [GEN_W-1:0] gen_count_t;

    // update engine states
    typedef enum logic [2:0] {
        IDLE,
        NEXT_CELL,
        NEIGHBOURS,
        CURRENT_CELL,
        UPDATE_CELL
    } engine_state_t;

    // generation controller states, prefixed to keep clear of the engine literals
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LAUNCH,
        CTRL_WAIT_DONE,
        CTRL_SWAP
    } ctrl_state_t;

endpackage
